/* fetch_frontend.f */
hdl/fetch_pkg.sv
hdl/if_stage_1.sv
hdl/branch_predictor.sv
hdl/imem_arbiter.sv
hdl/inst_mem.sv
hdl/if_stage_2.sv
hdl/fetch_top.sv
verification/tb_fetch_top.sv

/* hdl/branch_predictor.sv */
// Branch predictor
// Direct-mapped table of 2-bit counters and targets, trained by execute
module branch_predictor (
    input  logic                           clk_i,
    input  logic                           rstn_i,
    input  fetch_pkg::addr_pc_t            pc_fetch_i,
    input  fetch_pkg::exe_if_branch_pred_t exe_i,
    output fetch_pkg::bpred_t              bpred_o
);
    import fetch_pkg::*;

    // Table state, no tags
    logic     is_branch_q [0:BP_ENTRIES-1];
    logic [1:0] cnt_q     [0:BP_ENTRIES-1];
    addr_pc_t target_q    [0:BP_ENTRIES-1];

    logic [BP_IDX_W-1:0] rd_idx;
    logic [BP_IDX_W-1:0] upd_idx;
    logic [1:0]          upd_cnt;
    logic [1:0]          upd_cnt_next;

    // Word index from PC bits 7 to 2
    assign rd_idx  = pc_fetch_i[BP_IDX_W+1:2];
    assign upd_idx = exe_i.pc_execution[BP_IDX_W+1:2];

    // Saturating step toward the resolved outcome
    assign upd_cnt = cnt_q[upd_idx];

    always_comb begin
        upd_cnt_next = upd_cnt;
        if (exe_i.branch_taken_result_exe) begin
            if (upd_cnt != 2'b11) begin
                upd_cnt_next = upd_cnt + 2'b01;
            end
        end else begin
            if (upd_cnt != 2'b00) begin
                upd_cnt_next = upd_cnt - 2'b01;
            end
        end
    end

    // Control state, cleared on reset
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < BP_ENTRIES; i++) begin
                is_branch_q[i] <= 1'b0;
                cnt_q[i]       <= 2'b00;
            end
        end else if (exe_i.is_branch_exe) begin
            is_branch_q[upd_idx] <= 1'b1;
            cnt_q[upd_idx]       <= upd_cnt_next;
        end
    end

    // Targets are payload only
    always_ff @(posedge clk_i) begin
        if (exe_i.is_branch_exe) begin
            target_q[upd_idx] <= exe_i.branch_addr_result_exe;
        end
    end

    // Lookup, taken on counter MSB of a known branch
    assign bpred_o.is_branch = is_branch_q[rd_idx];
    assign bpred_o.decision  = (is_branch_q[rd_idx] && cnt_q[rd_idx][1]) ?
                               PRED_TAKEN : PRED_NOT_TAKEN;
    assign bpred_o.pred_addr = target_q[rd_idx];

endmodule

/* hdl/fetch_pkg.sv */
// Fetch front end package
// Shared types, select encodings, exception causes and sizes
package fetch_pkg;

    // Instruction memory geometry, one 32-bit word per entry
    localparam int IMEM_WORDS = 256;
    localparam int IMEM_IDX_W = 8;

    // Branch predictor table geometry
    localparam int BP_ENTRIES = 64;
    localparam int BP_IDX_W   = 6;

    // Top valid bit of an Sv39 virtual address
    localparam int VA_MSB = 38;

    typedef logic [63:0] addr_pc_t;
    typedef logic [31:0] inst_t;

    // Next PC source chosen by the control unit
    typedef enum logic [1:0] {
        NEXT_PC_SEL_KEEP_PC    = 2'b00,
        NEXT_PC_SEL_BP_OR_PC_4 = 2'b01,
        NEXT_PC_SEL_JUMP       = 2'b10,
        NEXT_PC_SEL_DEBUG      = 2'b11
    } next_pc_sel_t;

    typedef struct packed {
        next_pc_sel_t next_pc;
    } cu_if_t;

    // Resolved branch from execute, trains the predictor
    typedef struct packed {
        logic     is_branch_exe;
        logic     branch_taken_result_exe;
        addr_pc_t pc_execution;
        addr_pc_t branch_addr_result_exe;
    } exe_if_branch_pred_t;

    typedef enum logic {
        PRED_NOT_TAKEN = 1'b0,
        PRED_TAKEN     = 1'b1
    } branch_pred_decision_t;

    typedef struct packed {
        logic                  is_branch;
        branch_pred_decision_t decision;
        addr_pc_t              pred_addr;
    } bpred_t;

    // Fetch exception causes, RISC-V mcause numbering
    typedef enum logic [3:0] {
        INSTR_ADDR_MISALIGNED = 4'd0,
        INSTR_ACCESS_FAULT    = 4'd1
    } exception_cause_t;

    typedef struct packed {
        exception_cause_t cause;
        addr_pc_t         origin;
        logic             valid;
    } exception_t;

    // Packet from the first to the second fetch stage
    typedef struct packed {
        addr_pc_t   pc_inst;
        exception_t ex;
        bpred_t     bpred;
        logic       valid;
    } if_1_if_2_stage_t;

    // Fetched instruction presented at the top level
    typedef struct packed {
        addr_pc_t   pc_inst;
        inst_t      inst;
        exception_t ex;
        bpred_t     bpred;
        logic       valid;
    } fetch_out_t;

    // Request on the single instruction memory port
    typedef struct packed {
        logic                  valid;
        logic                  we;
        logic [IMEM_IDX_W-1:0] index;
        inst_t                 wdata;
    } mem_req_t;

endpackage

/* hdl/fetch_top.sv */
// Fetch front end top level
// Both fetch stages, branch predictor, memory arbiter and instruction memory
module fetch_top (
    input  logic                              clk_i,
    input  logic                              rstn_i,
    input  fetch_pkg::addr_pc_t               reset_addr_i,
    input  logic                              stall_i,
    input  logic                              stall_debug_i,
    input  fetch_pkg::cu_if_t                 cu_if_i,
    input  fetch_pkg::addr_pc_t               pc_jump_i,
    input  fetch_pkg::exe_if_branch_pred_t    exe_if_branch_pred_i,
    input  logic                              load_we_i,
    input  logic [fetch_pkg::IMEM_IDX_W-1:0]  load_index_i,
    input  fetch_pkg::inst_t                  load_data_i,
    output fetch_pkg::fetch_out_t             fetch_o
);
    import fetch_pkg::*;

    addr_pc_t         pc;
    bpred_t           bpred;
    mem_req_t         fetch_req;
    mem_req_t         load_req;
    mem_req_t         mem_req;
    logic             fetch_grant;
    inst_t            rdata;
    if_1_if_2_stage_t stage;

    // Loader is a write-only requester
    assign load_req.valid = load_we_i;
    assign load_req.we    = load_we_i;
    assign load_req.index = load_index_i;
    assign load_req.wdata = load_data_i;

    if_stage_1 i_if_stage_1 (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .reset_addr_i (reset_addr_i),
        .stall_i      (stall_i),
        .stall_debug_i(stall_debug_i),
        .cu_if_i      (cu_if_i),
        .pc_jump_i    (pc_jump_i),
        .fetch_grant_i(fetch_grant),
        .bpred_i      (bpred),
        .pc_o         (pc),
        .fetch_req_o  (fetch_req),
        .stage_o      (stage)
    );

    branch_predictor i_branch_predictor (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .pc_fetch_i(pc),
        .exe_i     (exe_if_branch_pred_i),
        .bpred_o   (bpred)
    );

    imem_arbiter i_imem_arbiter (
        .load_req_i   (load_req),
        .fetch_req_i  (fetch_req),
        .mem_req_o    (mem_req),
        .fetch_grant_o(fetch_grant)
    );

    inst_mem i_inst_mem (
        .clk_i  (clk_i),
        .req_i  (mem_req),
        .rdata_o(rdata)
    );

    if_stage_2 i_if_stage_2 (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .stage_i(stage),
        .rdata_i(rdata),
        .fetch_o(fetch_o)
    );

endmodule

/* hdl/if_stage_1.sv */
// First fetch stage
// Holds the PC, selects the next PC and flags fetch exceptions
module if_stage_1 (
    input  logic                        clk_i,
    input  logic                        rstn_i,
    input  fetch_pkg::addr_pc_t         reset_addr_i,
    input  logic                        stall_i,
    input  logic                        stall_debug_i,
    input  fetch_pkg::cu_if_t           cu_if_i,
    input  fetch_pkg::addr_pc_t         pc_jump_i,
    input  logic                        fetch_grant_i,
    input  fetch_pkg::bpred_t           bpred_i,
    output fetch_pkg::addr_pc_t         pc_o,
    output fetch_pkg::mem_req_t         fetch_req_o,
    output fetch_pkg::if_1_if_2_stage_t stage_o
);
    import fetch_pkg::*;

    addr_pc_t   pc_q;
    addr_pc_t   next_pc;
    logic       pred_taken;
    logic       misaligned;
    logic       addr_fault;
    exception_t ex;

    // Predictor only redirects on a known branch predicted taken
    assign pred_taken = bpred_i.is_branch && (bpred_i.decision == PRED_TAKEN);

    always_comb begin
        case (cu_if_i.next_pc)
            NEXT_PC_SEL_KEEP_PC: begin
                next_pc = pc_q;
            end
            NEXT_PC_SEL_BP_OR_PC_4: begin
                if (pred_taken) begin
                    next_pc = bpred_i.pred_addr;
                end else begin
                    next_pc = pc_q + 64'd4;
                end
            end
            // Jump and debug both redirect to the external target
            default: begin
                next_pc = pc_jump_i;
            end
        endcase
    end

    // PC only advances when the memory port is ours
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            pc_q <= reset_addr_i;
        end else if (fetch_grant_i) begin
            pc_q <= next_pc;
        end
    end

    // Word alignment check
    assign misaligned = |pc_q[1:0];

    // Sv39: bits 63 down to 38 must be all zeros or all ones
    assign addr_fault = !(&pc_q[63:VA_MSB]) && (|pc_q[63:VA_MSB]);

    // Misalignment wins over the access fault
    always_comb begin
        ex.origin = pc_q;
        if (misaligned) begin
            ex.cause = INSTR_ADDR_MISALIGNED;
            ex.valid = 1'b1;
        end else if (addr_fault) begin
            ex.cause = INSTR_ACCESS_FAULT;
            ex.valid = 1'b1;
        end else begin
            ex.cause = INSTR_ADDR_MISALIGNED;
            ex.valid = 1'b0;
        end
    end

    // Read request, word indexed, never writes
    assign fetch_req_o.valid = !misaligned && !addr_fault && !stall_debug_i;
    assign fetch_req_o.we    = 1'b0;
    assign fetch_req_o.index = pc_q[IMEM_IDX_W+1:2];
    assign fetch_req_o.wdata = '0;

    // Packet toward stage 2
    assign stage_o.pc_inst = pc_q;
    assign stage_o.ex      = ex;
    assign stage_o.bpred   = bpred_i;
    // No packet while stalled or while the loader owns the port
    assign stage_o.valid   = !stall_i && !stall_debug_i && fetch_grant_i
                             && (fetch_req_o.valid || ex.valid);

    // Current PC drives the predictor lookup
    assign pc_o = pc_q;

endmodule

/* hdl/if_stage_2.sv */
// Second fetch stage
// Registers the stage 1 packet and joins it with the memory word
module if_stage_2 (
    input  logic                        clk_i,
    input  logic                        rstn_i,
    input  fetch_pkg::if_1_if_2_stage_t stage_i,
    input  fetch_pkg::inst_t            rdata_i,
    output fetch_pkg::fetch_out_t       fetch_o
);
    import fetch_pkg::*;

    logic       valid_q;
    addr_pc_t   pc_q;
    exception_t ex_q;
    bpred_t     bpred_q;

    // Valid is the only control bit
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= stage_i.valid;
        end
    end

    // Packet payload, same edge as the memory read
    always_ff @(posedge clk_i) begin
        pc_q    <= stage_i.pc_inst;
        ex_q    <= stage_i.ex;
        bpred_q <= stage_i.bpred;
    end

    assign fetch_o.pc_inst = pc_q;
    // Exception packets issued no read
    assign fetch_o.inst    = ex_q.valid ? '0 : rdata_i;
    assign fetch_o.ex      = ex_q;
    assign fetch_o.bpred   = bpred_q;
    assign fetch_o.valid   = valid_q;

endmodule

/* hdl/imem_arbiter.sv */
// Instruction memory arbiter
// Fixed priority, program loader ahead of the fetch stage
module imem_arbiter (
    input  fetch_pkg::mem_req_t load_req_i,
    input  fetch_pkg::mem_req_t fetch_req_i,
    output fetch_pkg::mem_req_t mem_req_o,
    output logic                fetch_grant_o
);
    import fetch_pkg::*;

    logic load_win;

    // Any pending load takes the port
    assign load_win = load_req_i.valid;

    // Forward the winner to the memory
    always_comb begin
        if (load_win) begin
            mem_req_o = load_req_i;
        end else begin
            mem_req_o = fetch_req_i;
        end
    end

    // Grant is a level, also high for an idle fetch
    assign fetch_grant_o = !load_win;

endmodule

/* hdl/inst_mem.sv */
// Instruction memory
// Single port, synchronous read and write, no content reset
module inst_mem (
    input  logic                clk_i,
    input  fetch_pkg::mem_req_t req_i,
    output fetch_pkg::inst_t    rdata_o
);
    import fetch_pkg::*;

    inst_t mem_q [0:IMEM_WORDS-1];
    inst_t rdata_q;

    always_ff @(posedge clk_i) begin
        if (req_i.valid) begin
            if (req_i.we) begin
                mem_q[req_i.index] <= req_i.wdata;
            end else begin
                // Read data lands one cycle after the request
                rdata_q <= mem_q[req_i.index];
            end
        end
    end

    assign rdata_o = rdata_q;

endmodule

/* run_sim.sh */
#!/bin/sh
# Compile the fetch front end testbench with Verilator and run it
# Exit status is nonzero when the simulation fails

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 \
    --top-module tb_fetch_top \
    -Mdir obj_dir -o tb_fetch_top \
    -f fetch_frontend.f &&
./obj_dir/tb_fetch_top || exit 1

/* verification/tb_fetch_top.sv */
// Testbench for the fetch front end
// Reference model of PC, memory and predictor checked by concurrent assertions
module tb_fetch_top;
    import fetch_pkg::*;

    // Word aligned Sv39 address at memory index 0
    localparam addr_pc_t RESET_ADDR = 64'h0000_0000_0000_1000;

    logic                  clk_i;
    logic                  rstn_i;
    addr_pc_t              reset_addr_i;
    logic                  stall_i;
    logic                  stall_debug_i;
    cu_if_t                cu_if_i;
    addr_pc_t              pc_jump_i;
    exe_if_branch_pred_t   exe_if_branch_pred_i;
    logic                  load_we_i;
    logic [IMEM_IDX_W-1:0] load_index_i;
    inst_t                 load_data_i;
    fetch_out_t            fetch_o;

    string test_name;

    // Model state
    addr_pc_t   m_pc;
    inst_t      m_mem [0:IMEM_WORDS-1];
    logic       m_isb [0:BP_ENTRIES-1];
    logic [1:0] m_cnt [0:BP_ENTRIES-1];
    addr_pc_t   m_tgt [0:BP_ENTRIES-1];

    // Expected fetch_o lags the model PC by one cycle
    logic                  e_valid;
    addr_pc_t              e_pc;
    inst_t                 e_inst;
    logic                  e_ex_valid;
    exception_cause_t      e_cause;
    logic                  e_isb;
    branch_pred_decision_t e_dec;
    addr_pc_t              e_tgt;

    // Model scratch values
    logic                grant;
    logic                misal;
    logic                fault;
    logic                ex_v;
    logic                pred_tk;
    logic [BP_IDX_W-1:0] rd_idx;
    logic [BP_IDX_W-1:0] up_idx;
    logic [1:0]          up_cnt;

    addr_pc_t slot;
    addr_pc_t br_pc;
    addr_pc_t br_tgt;
    addr_pc_t hold_pc;

    fetch_top i_dut (
        .clk_i               (clk_i),
        .rstn_i              (rstn_i),
        .reset_addr_i        (reset_addr_i),
        .stall_i             (stall_i),
        .stall_debug_i       (stall_debug_i),
        .cu_if_i             (cu_if_i),
        .pc_jump_i           (pc_jump_i),
        .exe_if_branch_pred_i(exe_if_branch_pred_i),
        .load_we_i           (load_we_i),
        .load_index_i        (load_index_i),
        .load_data_i         (load_data_i),
        .fetch_o             (fetch_o)
    );

    initial clk_i = 1'b0;
    always #2 clk_i = ~clk_i;

    // Reference model clocked with the DUT
    always @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            m_pc    <= reset_addr_i;
            e_valid <= 1'b0;
            for (int i = 0; i < BP_ENTRIES; i++) begin
                m_isb[i] <= 1'b0;
                m_cnt[i] <= 2'b00;
            end
        end else begin
            // Loader wins the port
            grant   = !load_we_i;
            misal   = m_pc[1:0] != 2'b00;
            // Upper bits must copy bit 38 under Sv39
            fault   = m_pc[63:VA_MSB+1] != {(63-VA_MSB){m_pc[VA_MSB]}};
            ex_v    = misal || fault;
            rd_idx  = m_pc[BP_IDX_W+1:2];
            pred_tk = m_isb[rd_idx] && m_cnt[rd_idx][1];

            // Every unstalled granted PC yields a packet
            e_valid    <= grant && !stall_i && !stall_debug_i;
            e_pc       <= m_pc;
            e_ex_valid <= ex_v;
            e_cause    <= misal ? INSTR_ADDR_MISALIGNED : INSTR_ACCESS_FAULT;
            e_isb      <= m_isb[rd_idx];
            e_dec      <= pred_tk ? PRED_TAKEN : PRED_NOT_TAKEN;
            e_tgt      <= m_tgt[rd_idx];
            // No read for an exception packet
            e_inst     <= ex_v ? '0 : m_mem[m_pc[IMEM_IDX_W+1:2]];

            if (grant) begin
                case (cu_if_i.next_pc)
                    NEXT_PC_SEL_KEEP_PC: m_pc <= m_pc;
                    NEXT_PC_SEL_BP_OR_PC_4: m_pc <= pred_tk ? m_tgt[rd_idx] : m_pc + 64'd4;
                    default: m_pc <= pc_jump_i;
                endcase
            end
            if (load_we_i) begin
                m_mem[load_index_i] <= load_data_i;
            end
            // Counter saturates at 0 and 3
            if (exe_if_branch_pred_i.is_branch_exe) begin
                up_idx = exe_if_branch_pred_i.pc_execution[BP_IDX_W+1:2];
                up_cnt = m_cnt[up_idx];
                if (exe_if_branch_pred_i.branch_taken_result_exe && up_cnt != 2'b11) begin
                    up_cnt = up_cnt + 2'b01;
                end else if (!exe_if_branch_pred_i.branch_taken_result_exe
                             && up_cnt != 2'b00) begin
                    up_cnt = up_cnt - 2'b01;
                end
                m_isb[up_idx] <= 1'b1;
                m_cnt[up_idx] <= up_cnt;
                m_tgt[up_idx] <= exe_if_branch_pred_i.branch_addr_result_exe;
            end
        end
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string field, input logic [63:0] exp,
                                   input logic [63:0] act);
        stop_with_failure($sformatf("Mismatch %s %s: expected %h actual %h",
                                    test_name, field, exp, act));
    endtask

    // Checks sampled at the falling edge
    a_valid: assert property (@(negedge clk_i) disable iff (!rstn_i)
        fetch_o.valid == e_valid)
        else report_mismatch("valid", 64'(e_valid), 64'(fetch_o.valid));
    a_pc: assert property (@(negedge clk_i) disable iff (!rstn_i)
        e_valid |-> fetch_o.pc_inst == e_pc)
        else report_mismatch("pc_inst", e_pc, fetch_o.pc_inst);
    a_inst: assert property (@(negedge clk_i) disable iff (!rstn_i)
        e_valid |-> fetch_o.inst == e_inst)
        else report_mismatch("inst", 64'(e_inst), 64'(fetch_o.inst));
    a_ex_valid: assert property (@(negedge clk_i) disable iff (!rstn_i)
        e_valid |-> fetch_o.ex.valid == e_ex_valid)
        else report_mismatch("ex.valid", 64'(e_ex_valid), 64'(fetch_o.ex.valid));
    a_cause: assert property (@(negedge clk_i) disable iff (!rstn_i)
        e_valid && e_ex_valid |-> fetch_o.ex.cause == e_cause)
        else report_mismatch("ex.cause", 64'(e_cause), 64'(fetch_o.ex.cause));
    a_origin: assert property (@(negedge clk_i) disable iff (!rstn_i)
        e_valid && e_ex_valid |-> fetch_o.ex.origin == e_pc)
        else report_mismatch("ex.origin", e_pc, fetch_o.ex.origin);
    a_is_branch: assert property (@(negedge clk_i) disable iff (!rstn_i)
        e_valid |-> fetch_o.bpred.is_branch == e_isb)
        else report_mismatch("is_branch", 64'(e_isb), 64'(fetch_o.bpred.is_branch));
    a_decision: assert property (@(negedge clk_i) disable iff (!rstn_i)
        e_valid |-> fetch_o.bpred.decision == e_dec)
        else report_mismatch("decision", 64'(e_dec), 64'(fetch_o.bpred.decision));
    // Targets only exist for trained entries
    a_target: assert property (@(negedge clk_i) disable iff (!rstn_i)
        e_valid && e_isb |-> fetch_o.bpred.pred_addr == e_tgt)
        else report_mismatch("pred_addr", e_tgt, fetch_o.bpred.pred_addr);

    task automatic next_cycle();
        @(posedge clk_i);
        #1;
    endtask

    // Wait for a valid fetch of one PC
    task automatic wait_fetch(input addr_pc_t pc, input int max_cycles);
        int cycles;
        cycles = 0;
        while (!(fetch_o.valid && fetch_o.pc_inst == pc)) begin
            if (cycles == max_cycles) begin
                stop_with_failure($sformatf("No valid fetch of PC %h in %s", pc, test_name));
            end else begin
                next_cycle();
                cycles++;
            end
        end
    endtask

    task automatic count_fetches(input int n, input int max_cycles);
        int seen;
        int cycles;
        seen   = 0;
        cycles = 0;
        while (seen < n) begin
            if (cycles == max_cycles) begin
                stop_with_failure($sformatf("Too few valid fetches in %s", test_name));
            end else begin
                next_cycle();
                cycles++;
                if (fetch_o.valid) begin
                    seen++;
                end
            end
        end
    endtask

    // One cycle of jump or debug select before sequential fetch
    task automatic redirect(input addr_pc_t target, input next_pc_sel_t sel);
        cu_if_i.next_pc = sel;
        pc_jump_i       = target;
        next_cycle();
        cu_if_i.next_pc = NEXT_PC_SEL_BP_OR_PC_4;
    endtask

    task automatic train(input addr_pc_t pc, input addr_pc_t target, input logic taken);
        exe_if_branch_pred_i.is_branch_exe           = 1'b1;
        exe_if_branch_pred_i.branch_taken_result_exe = taken;
        exe_if_branch_pred_i.pc_execution            = pc;
        exe_if_branch_pred_i.branch_addr_result_exe  = target;
        repeat (2) next_cycle();
        exe_if_branch_pred_i = '0;
    endtask

    initial begin
        void'($urandom(30));
        rstn_i               = 1'b0;
        reset_addr_i         = RESET_ADDR;
        stall_i              = 1'b0;
        stall_debug_i        = 1'b0;
        cu_if_i.next_pc      = NEXT_PC_SEL_KEEP_PC;
        pc_jump_i            = '0;
        exe_if_branch_pred_i = '0;
        load_we_i            = 1'b0;
        load_index_i         = '0;
        load_data_i          = '0;
        test_name            = "reset";
        repeat (2) @(posedge clk_i);
        #1 rstn_i = 1'b1;

        // Random program over the whole memory
        test_name = "load_and_sequential";
        for (int i = 0; i < IMEM_WORDS; i++) begin
            load_we_i    = 1'b1;
            load_index_i = IMEM_IDX_W'(i);
            load_data_i  = $urandom();
            next_cycle();
        end
        load_we_i       = 1'b0;
        cu_if_i.next_pc = NEXT_PC_SEL_BP_OR_PC_4;
        wait_fetch(RESET_ADDR, 8);
        count_fetches(16, 40);

        // Loader steals the port and rewrites the held PC
        test_name    = "loader_priority";
        hold_pc      = m_pc;
        load_we_i    = 1'b1;
        load_index_i = hold_pc[IMEM_IDX_W+1:2];
        load_data_i  = $urandom();
        next_cycle();
        load_data_i  = $urandom();
        next_cycle();
        load_we_i    = 1'b0;
        wait_fetch(hold_pc, 8);

        test_name = "jump";
        br_tgt    = RESET_ADDR + 64'd4 * addr_pc_t'($urandom_range(0, 63));
        redirect(br_tgt, NEXT_PC_SEL_JUMP);
        wait_fetch(br_tgt, 8);
        test_name = "debug";
        br_tgt    = RESET_ADDR + 64'd4 * addr_pc_t'($urandom_range(0, 63));
        redirect(br_tgt, NEXT_PC_SEL_DEBUG);
        wait_fetch(br_tgt, 8);

        test_name = "misaligned";
        redirect(RESET_ADDR + 64'd2, NEXT_PC_SEL_JUMP);
        wait_fetch(RESET_ADDR + 64'd2, 8);
        // Bit 39 set with bit 38 clear
        test_name = "access_fault";
        redirect(64'h0000_0080_0000_1000, NEXT_PC_SEL_JUMP);
        wait_fetch(64'h0000_0080_0000_1000, 8);
        redirect(RESET_ADDR, NEXT_PC_SEL_JUMP);
        wait_fetch(RESET_ADDR, 8);

        // Branch slot and target never share a table entry
        test_name = "predict_taken";
        slot      = addr_pc_t'($urandom_range(4, 40));
        br_pc     = RESET_ADDR + 64'd4 * slot;
        br_tgt    = RESET_ADDR + 64'd4 * addr_pc_t'($urandom_range(44, 60));
        train(br_pc, br_tgt, 1'b1);
        redirect(br_pc, NEXT_PC_SEL_JUMP);
        wait_fetch(br_pc, 8);
        wait_fetch(br_tgt, 4);
        test_name = "predict_not_taken";
        train(br_pc, br_tgt, 1'b0);
        redirect(br_pc, NEXT_PC_SEL_JUMP);
        wait_fetch(br_pc, 8);
        wait_fetch(br_pc + 64'd4, 4);

        test_name = "stall";
        stall_i   = 1'b1;
        repeat (3) next_cycle();
        stall_i   = 1'b0;
        count_fetches(2, 8);
        test_name     = "stall_debug";
        stall_debug_i = 1'b1;
        repeat (3) next_cycle();
        stall_debug_i = 1'b0;
        count_fetches(2, 8);

        // Reset in the middle of fetching
        test_name = "reset_restart";
        rstn_i    = 1'b0;
        repeat (2) next_cycle();
        rstn_i    = 1'b1;
        wait_fetch(RESET_ADDR, 8);
        count_fetches(4, 12);

        $display("sim passed");
        $finish;
    end

endmodule
